/* exec_stage.f */
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
exec_operands_if.sv
exec_forward.sv
exec_decode.sv
exec_stage.sv
tb_exec_stage.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' exec_stage.f)

.PHONY: run clean

run: obj_dir/Vtb_exec_stage
	./obj_dir/Vtb_exec_stage | tee sim.log
	grep -q "All tests passed!" sim.log

obj_dir/Vtb_exec_stage: exec_stage.f exec_defines.svh $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_stage \
		-f exec_stage.f -o Vtb_exec_stage

clean:
	rm -rf obj_dir sim.log

/* tb_exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module tb_exec_stage;

    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam int VECTORS        = 200;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 4 * NUM_TESTS * VECTORS + 200;

    typedef struct packed {
        logic [`XLEN-1:0]    operand_a;
        logic [`XLEN-1:0]    operand_b;
        logic [`SHAMT_W-1:0] shamt;
        alu_sel_e            alu_sel;
        logic                flush;
        ex_ctrl_t            ctrl;
        logic [`XLEN-1:0]    mem_data;
    } exec_expect_t;

    logic                clk_i = 1'b0;
    logic                rstn_i = 1'b0;
    logic [`XLEN-1:0]    instr_i = '0, imm_i = '0, pc_i = '0, alu_result_i = '0;
    logic [`XLEN-1:0]    rs1_i = '0, rs2_i = '0, rs1_fwd_i = '0, rs2_fwd_i = '0;
    logic                fwd_mem_rs1_i = 1'b0, fwd_wb_rs1_i = 1'b0;
    logic                fwd_mem_rs2_i = 1'b0, fwd_wb_rs2_i = 1'b0;
    logic [`XLEN-1:0]    operand_a_o, operand_b_o, mem_data_o, alu_result_o, pc_o, instr_o;
    logic [`SHAMT_W-1:0] shamt_o;
    alu_sel_e            alu_sel_o;
    logic                flush_o, jump_o, reg_write_o, mem_write_o;

    integer           seed = 78;
    int               errors = 0;
    int               test_errors = 0;
    int               tests_failed = 0;
    int               cycle_count = 0;
    logic             check_en = 1'b0;
    exec_expect_t     exp_q = '0;              // Expected register contents
    logic [`XLEN-1:0] alu_result_q = '0, pc_q = '0, instr_q = '0;

    exec_stage uut (.*);

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Models the hazard mux, either enable wins
    function automatic logic [31:0] forward_value(input logic [31:0] rf, input logic [31:0] hz,
                                                  input logic sel);
        return sel ? hz : rf;
    endfunction

    function automatic exec_expect_t expect_exec(input logic [31:0] instr, input logic [31:0] rs1,
                                                 input logic [31:0] rs2, input logic [31:0] imm,
                                                 input logic [31:0] pc);
        exec_expect_t e;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic         bad;
        e   = '0;
        f3  = instr[14:12];
        f7  = instr[31:25];
        bad = 1'b0;
        case (instr[6:0])
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                e.operand_a      = imm;
                e.operand_b      = (instr[6:0] == OPC_LUI) ? '0 : pc;
                e.ctrl.jump      = (instr[6:0] == OPC_JAL);
                e.ctrl.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                e.operand_a = imm;
                e.operand_b = pc;
                case (f3)
                    F3_BEQ:  e.ctrl.jump = (rs1 == rs2);
                    F3_BNE:  e.ctrl.jump = (rs1 != rs2);
                    F3_BLT:  e.ctrl.jump = ($signed(rs1) < $signed(rs2));
                    F3_BGE:  e.ctrl.jump = ($signed(rs1) >= $signed(rs2));
                    F3_BLTU: e.ctrl.jump = (rs1 < rs2);
                    F3_BGEU: e.ctrl.jump = (rs1 >= rs2);
                    default: bad = 1'b1;
                endcase
            end
            OPC_JALR, OPC_LOAD, OPC_STORE: begin
                e.operand_a      = rs1;
                e.operand_b      = imm;
                e.ctrl.jump      = (instr[6:0] == OPC_JALR);
                e.ctrl.reg_write = (instr[6:0] != OPC_STORE);
                e.ctrl.mem_write = (instr[6:0] == OPC_STORE);
                e.mem_data       = (instr[6:0] == OPC_STORE) ? rs2 : '0;
                if (instr[6:0] == OPC_JALR) begin
                    bad = (f3 != 3'd0);
                end else if (instr[6:0] == OPC_LOAD) begin
                    bad = (f3 == 3'd3) || (f3 > 3'd5);
                end else begin
                    bad = (f3 > 3'd2);
                end
            end
            OPC_OP_IMM: begin
                e.operand_a      = rs1;
                e.operand_b      = imm;
                e.ctrl.reg_write = 1'b1;
                case (f3)
                    F3_SLT:  e.alu_sel = ($signed(rs1) < $signed(imm)) ? ALU_ONE : ALU_ZERO;
                    F3_SLTU: e.alu_sel = (rs1 < imm) ? ALU_ONE : ALU_ZERO;
                    F3_XOR:  e.alu_sel = ALU_XOR;
                    F3_OR:   e.alu_sel = ALU_OR;
                    F3_AND:  e.alu_sel = ALU_AND;
                    F3_SLL, F3_SR: begin
                        e.operand_b = '0;           // Shift amount comes from instr
                        e.shamt     = instr[24:20];
                        if (f3 == F3_SLL) begin
                            e.alu_sel = ALU_SLLI;
                        end else begin
                            e.alu_sel = (f7 == F7_ALT) ? ALU_SRAI : ALU_SRLI;
                        end
                        bad = !((f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == F3_SR)));
                    end
                    default: e.alu_sel = ALU_ADD;
                endcase
            end
            OPC_OP: begin
                e.operand_a      = rs1;
                e.operand_b      = rs2;
                e.ctrl.reg_write = 1'b1;
                bad = !((f7 == F7_BASE) || ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR))));
                case (f3)
                    F3_ADD:  e.alu_sel = (f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  e.alu_sel = ALU_SLL;
                    F3_SLT:  e.alu_sel = ($signed(rs1) < $signed(rs2)) ? ALU_ONE : ALU_ZERO;
                    F3_SLTU: e.alu_sel = (rs1 < rs2) ? ALU_ONE : ALU_ZERO;
                    F3_XOR:  e.alu_sel = ALU_XOR;
                    F3_SR:   e.alu_sel = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   e.alu_sel = ALU_OR;
                    default: e.alu_sel = ALU_AND;
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            e = '0;
        end
        e.flush = e.ctrl.jump;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Combinational outputs belong to this cycle, registered ones to the last
    always @(negedge clk_i) begin : compare_outputs
        exec_expect_t e;
        e = expect_exec(instr_i, forward_value(rs1_i, rs1_fwd_i, fwd_mem_rs1_i | fwd_wb_rs1_i),
                        forward_value(rs2_i, rs2_fwd_i, fwd_mem_rs2_i | fwd_wb_rs2_i),
                        imm_i, pc_i);
        if (check_en) begin
            check_value("operand_a_o", e.operand_a, operand_a_o);
            check_value("operand_b_o", e.operand_b, operand_b_o);
            check_value("shamt_o", 32'(e.shamt), 32'(shamt_o));
            check_value("alu_sel_o", 32'(e.alu_sel), 32'(alu_sel_o));
            check_value("flush_o", 32'(e.flush), 32'(flush_o));
            check_value("jump_o", 32'(exp_q.ctrl.jump), 32'(jump_o));
            check_value("reg_write_o", 32'(exp_q.ctrl.reg_write), 32'(reg_write_o));
            check_value("mem_write_o", 32'(exp_q.ctrl.mem_write), 32'(mem_write_o));
            check_value("mem_data_o", exp_q.mem_data, mem_data_o);
            check_value("alu_result_o", alu_result_q, alu_result_o);
            check_value("pc_o", pc_q, pc_o);
            check_value("instr_o", instr_q, instr_o);
        end
        exp_q        = rstn_i ? e : '0;   // Next edge loads or clears
        alu_result_q = rstn_i ? alu_result_i : '0;
        pc_q         = rstn_i ? pc_i : '0;
        instr_q      = rstn_i ? instr_i : '0;
    end

    task automatic apply_vector(input logic [31:0] instr, input logic [31:0] imm,
                                input logic [31:0] rs1, input logic [31:0] rs2,
                                input logic [31:0] fwd1, input logic [31:0] fwd2,
                                input logic [3:0] en);
        @(posedge clk_i);
        instr_i       <= instr;
        imm_i         <= imm;
        pc_i          <= rand_word() & 32'hffff_fffc;
        alu_result_i  <= rand_word();
        rs1_i         <= rs1;
        rs2_i         <= rs2;
        rs1_fwd_i     <= fwd1;
        rs2_fwd_i     <= fwd2;
        fwd_mem_rs1_i <= en[0];
        fwd_wb_rs1_i  <= en[1];
        fwd_mem_rs2_i <= en[2];
        fwd_wb_rs2_i  <= en[3];
    endtask

    task automatic pick_operands(output logic [31:0] a, output logic [31:0] b);
        a = rand_word();
        case (rand_below(4))
            0:       b = a;
            1:       b = a ^ 32'h8000_0000; // Signed and unsigned order disagree
            default: b = rand_word();
        endcase
    endtask

    task automatic make_instr(input int kind, output logic [31:0] instr, output logic [31:0] imm);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        int          pick;
        int          group;
        r     = rand_word();
        f3    = r[14:12];
        f7    = r[31:25];
        pick  = rand_below(8);
        group = (kind == 2) ? (pick[0] ? 1 : 3) : kind; // Forwarding mixes ALU and branches
        case (group)
            1: begin
                if (pick[1]) begin
                    f7    = (pick[2] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : F7_BASE;
                    instr = {f7, r[24:15], f3, r[11:7], OPC_OP};
                end else begin
                    if (f3 == F3_SLL) f7 = F7_BASE;
                    else if (f3 == F3_SR) f7 = pick[2] ? F7_ALT : F7_BASE;
                    instr = {f7, r[24:15], f3, r[11:7], OPC_OP_IMM};
                end
            end
            3: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3 = f3 ^ 3'b110; // Skip reserved funct3
                if (pick == 0) instr = {r[31:7], OPC_JAL};
                else if (pick == 1) instr = {r[31:15], F3_JALR, r[11:7], OPC_JALR};
                else instr = {r[31:15], f3, r[11:7], OPC_BRANCH};
            end
            4: begin
                if (pick == 0) instr = {r[31:7], OPC_LUI};
                else if (pick == 1) instr = {r[31:7], OPC_AUIPC};
                else if (pick < 5) instr = {r[31:15], (f3 == 3'd3 || f3 > 3'd5) ? f3 & 3'b101 : f3,
                                            r[11:7], OPC_LOAD};
                else instr = {r[31:15], 3'(rand_below(3)), r[11:7], OPC_STORE};
            end
            default: begin
                opc = r[6:0];
                while (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                   OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP}) opc = opc + 7'd1;
                case (pick)
                    0: instr = {r[31:7], opc};
                    1: instr = {f7 | 7'b0000001, r[24:15], f3, r[11:7], OPC_OP};
                    2: instr = {7'b0110000, 5'(rand_below(3)), r[19:15], F3_SLL, r[11:7],
                                OPC_OP_IMM};                       // CLZ, CTZ, CPOP
                    3: instr = {f7 | 7'b0000001, r[24:15], F3_SR, r[11:7], OPC_OP_IMM};
                    4: instr = {r[31:15], 2'b01, r[12], r[11:7], OPC_BRANCH};
                    5: instr = {r[31:15], f3 | 3'b001, r[11:7], OPC_JALR};
                    6: instr = {r[31:15], r[13] ? 3'b011 : {2'b11, r[12]}, r[11:7], OPC_LOAD};
                    default: instr = {r[31:15], (f3 < 3'd3) ? 3'd3 : f3, r[11:7], OPC_STORE};
                endcase
            end
        endcase
        if (instr[6:0] == OPC_LUI || instr[6:0] == OPC_AUIPC) imm = {instr[31:12], 12'h000};
        else imm = {{20{instr[31]}}, instr[31:20]};
    endtask

    task automatic finish_test(input string name);
        apply_vector('0, '0, '0, '0, '0, '0, 4'b0000); // Idle so the last vector's register is checked
        @(posedge clk_i);
        if (errors == test_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d mismatches", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic run_reset_test();
        apply_vector({20'h00100, 5'd1, OPC_JAL}, 32'h0000_0100, rand_word(), rand_word(),
                     '0, '0, 4'b0000);  // Would load jump and reg_write
        check_en = 1'b1;
        apply_vector({7'd0, 5'd2, 5'd1, F3_SW, 5'd4, OPC_STORE}, 32'h0000_0004, rand_word(),
                     32'h1357_9bdf, '0, '0, 4'b0000); // Would load mem_write and store data
        @(posedge clk_i);
        @(posedge clk_i);
        rstn_i <= 1'b1;                 // Fourth edge still sees reset
        @(negedge clk_i);
        check_value("jump_o", 32'd0, 32'(jump_o));
        check_value("reg_write_o", 32'd0, 32'(reg_write_o));
        check_value("mem_write_o", 32'd0, 32'(mem_write_o));
        check_value("mem_data_o", 32'd0, mem_data_o);
        check_value("alu_result_o", 32'd0, alu_result_o);
        check_value("pc_o", 32'd0, pc_o);
        check_value("instr_o", 32'd0, instr_o);
        finish_test("reset");
    endtask

    task automatic run_test(input int kind, input string name);
        logic [31:0] instr;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] fwd1;
        logic [31:0] fwd2;
        logic [3:0]  en;
        for (int i = 0; i < VECTORS; i++) begin
            make_instr(kind, instr, imm);
            pick_operands(rs1, rs2);
            pick_operands(fwd1, fwd2);
            en = (kind == 2 || kind == 4) ? 4'(rand_below(16)) : 4'b0000;
            apply_vector(instr, imm, rs1, rs2, fwd1, fwd2, en);
        end
        finish_test(name);
    endtask

    initial begin
        run_reset_test();
        run_test(1, "alu_ops");
        run_test(2, "forwarding");
        run_test(3, "branch_jump");
        run_test(4, "load_store");
        run_test(5, "unsupported");
        $display("%0d tests run, %0d failed, %0d mismatches", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_stage (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic [`XLEN-1:0]     instr_i,
    input  wire logic [`XLEN-1:0]     imm_i,
    input  wire logic [`XLEN-1:0]     pc_i,
    input  wire logic [`XLEN-1:0]     alu_result_i,
    input  wire logic [`XLEN-1:0]     rs1_i,
    input  wire logic [`XLEN-1:0]     rs2_i,
    input  wire logic [`XLEN-1:0]     rs1_fwd_i,
    input  wire logic [`XLEN-1:0]     rs2_fwd_i,
    input  wire logic                 fwd_mem_rs1_i,
    input  wire logic                 fwd_wb_rs1_i,
    input  wire logic                 fwd_mem_rs2_i,
    input  wire logic                 fwd_wb_rs2_i,
    output logic [`XLEN-1:0]          operand_a_o,
    output logic [`XLEN-1:0]          operand_b_o,
    output logic [`SHAMT_W-1:0]       shamt_o,
    output rv_isa_pkg::alu_sel_e      alu_sel_o,
    output logic                      flush_o,
    output logic                      jump_o,
    output logic                      reg_write_o,
    output logic                      mem_write_o,
    output logic [`XLEN-1:0]          mem_data_o,
    output logic [`XLEN-1:0]          alu_result_o,
    output logic [`XLEN-1:0]          pc_o,
    output logic [`XLEN-1:0]          instr_o
);

    exec_operands_if ops ();

    exec_forward u_forward (
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .rs1_fwd_i     (rs1_fwd_i),
        .rs2_fwd_i     (rs2_fwd_i),
        .fwd_mem_rs1_i (fwd_mem_rs1_i),
        .fwd_wb_rs1_i  (fwd_wb_rs1_i),
        .fwd_mem_rs2_i (fwd_mem_rs2_i),
        .fwd_wb_rs2_i  (fwd_wb_rs2_i),
        .ops           (ops.fwd)
    );

    exec_decode u_decode (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .instr_i      (instr_i),
        .imm_i        (imm_i),
        .pc_i         (pc_i),
        .alu_result_i (alu_result_i),
        .ops          (ops.dec),
        .operand_a_o  (operand_a_o),
        .operand_b_o  (operand_b_o),
        .shamt_o      (shamt_o),
        .alu_sel_o    (alu_sel_o),
        .flush_o      (flush_o),
        .jump_o       (jump_o),
        .reg_write_o  (reg_write_o),
        .mem_write_o  (mem_write_o),
        .mem_data_o   (mem_data_o),
        .alu_result_o (alu_result_o),
        .pc_o         (pc_o),
        .instr_o      (instr_o)
    );

endmodule

`default_nettype wire

/* exec_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_decode (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic [`XLEN-1:0]     instr_i,
    input  wire logic [`XLEN-1:0]     imm_i,
    input  wire logic [`XLEN-1:0]     pc_i,
    input  wire logic [`XLEN-1:0]     alu_result_i,
    exec_operands_if.dec              ops,
    output logic [`XLEN-1:0]          operand_a_o,
    output logic [`XLEN-1:0]          operand_b_o,
    output logic [`SHAMT_W-1:0]       shamt_o,
    output rv_isa_pkg::alu_sel_e      alu_sel_o,
    output logic                      flush_o,
    output logic                      jump_o,
    output logic                      reg_write_o,
    output logic                      mem_write_o,
    output logic [`XLEN-1:0]          mem_data_o,
    output logic [`XLEN-1:0]          alu_result_o,
    output logic [`XLEN-1:0]          pc_o,
    output logic [`XLEN-1:0]          instr_o
);

    import rv_isa_pkg::*;
    import exec_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             br_valid;
    logic             br_taken;
    logic             imm_lt;
    logic             imm_ltu;
    logic             illegal;
    ex_ctrl_t         ctrl_d;
    ex_ctrl_t         ctrl_q;
    logic [`XLEN-1:0] mem_data_d;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // SLTI/SLTIU compare against the immediate, not rs2
    assign imm_lt  = ($signed(ops.rs1_val) < $signed(imm_i));
    assign imm_ltu = (ops.rs1_val < imm_i);

    always_comb begin
        br_valid = 1'b1;
        br_taken = 1'b0;
        case (funct3)
            F3_BEQ:  br_taken = ops.eq;
            F3_BNE:  br_taken = ~ops.eq;
            F3_BLT:  br_taken = ops.lt;
            F3_BGE:  br_taken = ~ops.lt;
            F3_BLTU: br_taken = ops.ltu;
            F3_BGEU: br_taken = ~ops.ltu;
            default: br_valid = 1'b0; // 010, 011 reserved
        endcase
    end

    always_comb begin
        ctrl_d      = EX_CTRL_NOP;
        operand_a_o = '0;
        operand_b_o = '0;
        shamt_o     = '0;
        alu_sel_o   = ALU_ADD;
        mem_data_d  = '0;
        illegal     = 1'b0;
        case (opcode)
            OPC_LUI: begin
                operand_a_o      = imm_i; // Upper immediate already shifted
                ctrl_d.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                operand_a_o      = imm_i;
                operand_b_o      = pc_i;
                ctrl_d.reg_write = 1'b1;
            end
            OPC_JAL: begin
                operand_a_o      = imm_i;
                operand_b_o      = pc_i;  // Jump target
                ctrl_d.jump      = 1'b1;
                ctrl_d.reg_write = 1'b1;
            end
            OPC_JALR: begin
                operand_a_o      = ops.rs1_val;
                operand_b_o      = imm_i;
                ctrl_d.jump      = 1'b1;
                ctrl_d.reg_write = 1'b1;
                illegal          = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                operand_a_o = imm_i;
                operand_b_o = pc_i;       // Branch target
                ctrl_d.jump = br_taken;
                illegal     = ~br_valid;
            end
            OPC_LOAD: begin
                operand_a_o      = ops.rs1_val; // Effective address
                operand_b_o      = imm_i;
                ctrl_d.reg_write = 1'b1;
                illegal = !(funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
            end
            OPC_STORE: begin
                operand_a_o      = ops.rs1_val;
                operand_b_o      = imm_i;
                mem_data_d       = ops.rs2_val;
                ctrl_d.mem_write = 1'b1;
                illegal = !(funct3 inside {F3_SB, F3_SH, F3_SW});
            end
            OPC_OP_IMM: begin
                operand_a_o      = ops.rs1_val;
                operand_b_o      = imm_i;
                ctrl_d.reg_write = 1'b1;
                case (funct3)
                    F3_ADD:  alu_sel_o = ALU_ADD;
                    F3_SLT:  alu_sel_o = imm_lt ? ALU_ONE : ALU_ZERO;
                    F3_SLTU: alu_sel_o = imm_ltu ? ALU_ONE : ALU_ZERO;
                    F3_XOR:  alu_sel_o = ALU_XOR;
                    F3_OR:   alu_sel_o = ALU_OR;
                    F3_AND:  alu_sel_o = ALU_AND;
                    F3_SLL: begin
                        operand_b_o = '0;
                        shamt_o     = instr_i[24:20];
                        alu_sel_o   = ALU_SLLI;
                        illegal     = (funct7 != F7_BASE); // Count ops land here
                    end
                    F3_SR: begin
                        operand_b_o = '0;
                        shamt_o     = instr_i[24:20];
                        alu_sel_o   = (funct7 == F7_ALT) ? ALU_SRAI : ALU_SRLI;
                        illegal     = !(funct7 inside {F7_BASE, F7_ALT});
                    end
                endcase
            end
            OPC_OP: begin
                operand_a_o      = ops.rs1_val;
                operand_b_o      = ops.rs2_val;
                ctrl_d.reg_write = 1'b1;
                // Only ADD/SUB and SRL/SRA take the alternate funct7
                illegal = !((funct7 == F7_BASE) ||
                            ((funct7 == F7_ALT) && (funct3 inside {F3_ADD, F3_SR})));
                case (funct3)
                    F3_ADD:  alu_sel_o = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_sel_o = ALU_SLL;
                    F3_SLT:  alu_sel_o = ops.lt ? ALU_ONE : ALU_ZERO;
                    F3_SLTU: alu_sel_o = ops.ltu ? ALU_ONE : ALU_ZERO;
                    F3_XOR:  alu_sel_o = ALU_XOR;
                    F3_SR:   alu_sel_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_sel_o = ALU_OR;
                    F3_AND:  alu_sel_o = ALU_AND;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin // Squash to a bubble
            ctrl_d      = EX_CTRL_NOP;
            operand_a_o = '0;
            operand_b_o = '0;
            shamt_o     = '0;
            alu_sel_o   = ALU_ADD;
            mem_data_d  = '0;
        end
    end

    // Same-cycle redirect to fetch; jump_o repeats it one cycle later
    assign flush_o = ctrl_d.jump;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ctrl_q       <= EX_CTRL_NOP;
            mem_data_o   <= '0;
            alu_result_o <= '0;
            pc_o         <= '0;
            instr_o      <= '0;
        end else begin
            ctrl_q       <= ctrl_d;
            mem_data_o   <= mem_data_d;
            alu_result_o <= alu_result_i; // ALU answers in the same cycle
            pc_o         <= pc_i;
            instr_o      <= instr_i;
        end
    end

    assign jump_o      = ctrl_q.jump;
    assign reg_write_o = ctrl_q.reg_write;
    assign mem_write_o = ctrl_q.mem_write;

    // A redirect in the memory stage must never also be a store
    assert property (@(posedge clk_i) disable iff (!rstn_i) !(jump_o && mem_write_o))
        else $error("jump and mem_write both set in execute/memory register");

    assert property (@(posedge clk_i) disable iff (!rstn_i) alu_sel_o <= ALU_PASS_A)
        else $error("ALU select out of range");

endmodule

`default_nettype wire

/* exec_forward.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_forward (
    input  wire logic [`XLEN-1:0] rs1_i,
    input  wire logic [`XLEN-1:0] rs2_i,
    input  wire logic [`XLEN-1:0] rs1_fwd_i,
    input  wire logic [`XLEN-1:0] rs2_fwd_i,
    input  wire logic             fwd_mem_rs1_i,
    input  wire logic             fwd_wb_rs1_i,
    input  wire logic             fwd_mem_rs2_i,
    input  wire logic             fwd_wb_rs2_i,
    exec_operands_if.fwd          ops
);

    logic             use_fwd_rs1;
    logic             use_fwd_rs2;
    logic [`XLEN-1:0] rs1_sel;
    logic [`XLEN-1:0] rs2_sel;

    // Hazard unit already picked mem or wb, either one means take it
    assign use_fwd_rs1 = fwd_mem_rs1_i | fwd_wb_rs1_i;
    assign use_fwd_rs2 = fwd_mem_rs2_i | fwd_wb_rs2_i;

    assign rs1_sel = use_fwd_rs1 ? rs1_fwd_i : rs1_i;
    assign rs2_sel = use_fwd_rs2 ? rs2_fwd_i : rs2_i;

    assign ops.rs1_val = rs1_sel;
    assign ops.rs2_val = rs2_sel;

    // One comparator for branches and SLT/SLTU
    assign ops.eq  = (rs1_sel == rs2_sel);
    assign ops.lt  = ($signed(rs1_sel) < $signed(rs2_sel));
    assign ops.ltu = (rs1_sel < rs2_sel);

    always_comb begin
        if (use_fwd_rs1) begin
            assert (!$isunknown(rs1_fwd_i))
                else $error("rs1 forward selected with unknown hazard value");
        end
        if (use_fwd_rs2) begin
            assert (!$isunknown(rs2_fwd_i))
                else $error("rs2 forward selected with unknown hazard value");
        end
    end

endmodule

`default_nettype wire

/* exec_operands_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

interface exec_operands_if;

    logic [`XLEN-1:0] rs1_val; // After forwarding
    logic [`XLEN-1:0] rs2_val;
    logic             eq;      // rs1 == rs2
    logic             lt;      // Signed rs1 < rs2
    logic             ltu;     // Unsigned rs1 < rs2

    modport fwd (
        output rs1_val, rs2_val, eq, lt, ltu
    );

    modport dec (
        input rs1_val, rs2_val, eq, lt, ltu
    );

endinterface

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Control bits carried into the execute/memory register
    typedef struct packed {
        logic jump;      // Redirect fetch next cycle
        logic reg_write; // Write rd in writeback
        logic mem_write; // Store in memory stage
    } ex_ctrl_t;

    // Bubble, also used for unsupported encodings
    localparam ex_ctrl_t EX_CTRL_NOP = '{jump: 1'b0, reg_write: 1'b0, mem_write: 1'b0};

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

`include "exec_defines.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [`ALU_SEL_W-1:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_OR     = 5'd2,
        ALU_XOR    = 5'd3,
        ALU_AND    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLLI   = 5'd8,
        ALU_SRLI   = 5'd9,
        ALU_SRAI   = 5'd10,
        ALU_ZERO   = 5'd11, // Constant 0 result
        ALU_ONE    = 5'd12, // Constant 1 result
        ALU_PASS_A = 5'd13
    } alu_sel_e;

endpackage

`default_nettype wire

/* exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data and address width
`define XLEN 32

// Shift amount taken from instr[24:20]
`define SHAMT_W 5

// Width of the ALU operation select
`define ALU_SEL_W 5

`endif
